// File: pcUnit_settings.svh
`ifndef PCUNIT_SETTINGS_SVH
`define PCUNIT_SETTINGS_SVH

// Address and instruction word width
`define PC_WIDTH 16

// Instruction word fields
`define OPCODE_WIDTH  4
`define OPERAND_WIDTH 12

// Opcodes
`define OP_NEXT  4'h0
`define OP_JREL  4'h1
`define OP_JABS  4'h2
`define OP_RETI0 4'h3
`define OP_RETI1 4'h4

// Sequential step in bytes
`define PC_STEP 2

// Interrupt vectors
`define INT0_VECTOR 16'h0004
`define INT1_VECTOR 16'h0008

// Address after reset
`define RESET_PC 16'h0000

`endif

// File: pcPkg.sv
`default_nettype none

`include "pcUnit_settings.svh"

package pcPkg;

	// Widths that carry a meaning
	typedef logic [`PC_WIDTH-1:0] addrT;
	typedef logic [`PC_WIDTH-1:0] instrT;
	typedef logic [`OPCODE_WIDTH-1:0] opcodeT;
	typedef logic [`OPERAND_WIDTH-1:0] operandT;

	// Adder base
	typedef enum logic {
		BASE_PC,
		BASE_ZERO
	} baseSelT;

	// Adder offset
	typedef enum logic {
		OFFSET_TWO,
		OFFSET_DATA
	} offsetSelT;

	// Source of the next address
	typedef enum logic [2:0] {
		NEXT_SUM,
		NEXT_INTV0,
		NEXT_INTV1,
		NEXT_INTR0,
		NEXT_INTR1
	} nextSelT;

	// APB read master states
	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS
	} fetchStateT;

endpackage

`default_nettype wire

// File: instrDecode.sv
`default_nettype none

`include "pcUnit_settings.svh"

module instrDecode (
	input  wire logic            CLK,
	input  wire logic            rstN,
	input  wire pcPkg::instrT    instr,
	input  wire logic            instrValid,
	input  wire logic            int0Req,
	input  wire logic            int1Req,
	output logic                 pcLoad,
	output pcPkg::baseSelT       baseSel,
	output pcPkg::offsetSelT     offsetSel,
	output pcPkg::nextSelT       nextSel,
	output logic                 ldInt0,
	output logic                 ldInt1,
	output pcPkg::addrT          pcData
);

	localparam int ExtWidth = `PC_WIDTH - `OPERAND_WIDTH;

	pcPkg::opcodeT  opcode;
	pcPkg::operandT operand;
	logic           isNext;
	logic           isReti0;
	logic           isReti1;
	logic           take0;
	logic           take1;
	logic           inService0;
	logic           inService1;

	assign opcode  = instr[`PC_WIDTH-1 -: `OPCODE_WIDTH];
	assign operand = instr[`OPERAND_WIDTH-1:0];

	assign isReti0 = (opcode == `OP_RETI0);
	assign isReti1 = (opcode == `OP_RETI1);

	// Unknown opcodes fall through as NEXT
	assign isNext = (opcode != `OP_JREL) && (opcode != `OP_JABS) && !isReti0 && !isReti1;

	// Level 0 first, each only when idle
	assign take0 = instrValid && isNext && int0Req && !inService0;
	assign take1 = instrValid && isNext && !take0 && int1Req && !inService1;

	assign pcLoad = instrValid;
	assign ldInt0 = take0;
	assign ldInt1 = take1;

	always_comb begin
		baseSel   = pcPkg::BASE_PC;
		offsetSel = pcPkg::OFFSET_TWO;
		nextSel   = pcPkg::NEXT_SUM;
		pcData    = {{ExtWidth{1'b0}}, operand};
		case (opcode)
			`OP_JREL: begin
				offsetSel = pcPkg::OFFSET_DATA;
				pcData    = {{ExtWidth{operand[`OPERAND_WIDTH-1]}}, operand};
			end
			`OP_JABS: begin
				baseSel   = pcPkg::BASE_ZERO;
				offsetSel = pcPkg::OFFSET_DATA;
			end
			`OP_RETI0: begin
				nextSel = pcPkg::NEXT_INTR0;
			end
			`OP_RETI1: begin
				nextSel = pcPkg::NEXT_INTR1;
			end
			default: begin
				if (take0) begin
					nextSel = pcPkg::NEXT_INTV0;
				end else if (take1) begin
					nextSel = pcPkg::NEXT_INTV1;
				end
			end
		endcase
	end

	// In-service flags move with the PC update
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			inService0 <= 1'b0;
			inService1 <= 1'b0;
		end else if (instrValid) begin
			if (take0) begin
				inService0 <= 1'b1;
			end else if (isReti0) begin
				inService0 <= 1'b0;
			end
			if (take1) begin
				inService1 <= 1'b1;
			end else if (isReti1) begin
				inService1 <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: programCounter.sv
`default_nettype none

`include "pcUnit_settings.svh"

module programCounter (
	input  wire logic              CLK,
	input  wire logic              rstN,
	input  wire logic              pcLoad,
	input  wire pcPkg::baseSelT    baseSel,
	input  wire pcPkg::offsetSelT  offsetSel,
	input  wire pcPkg::nextSelT    nextSel,
	input  wire logic              ldInt0,
	input  wire logic              ldInt1,
	input  wire pcPkg::addrT       pcData,
	output pcPkg::addrT            pcA,
	output pcPkg::addrT            pcNext
);

	localparam pcPkg::addrT Step = pcPkg::addrT'(`PC_STEP);

	pcPkg::addrT baseVal;
	pcPkg::addrT offsetVal;
	pcPkg::addrT sum;
	pcPkg::addrT retAddr;
	pcPkg::addrT intRet0;
	pcPkg::addrT intRet1;

	// Base plus offset covers NEXT, JREL and JABS
	always_comb begin
		if (baseSel == pcPkg::BASE_ZERO) begin
			baseVal = '0;
		end else begin
			baseVal = pcA;
		end
		if (offsetSel == pcPkg::OFFSET_DATA) begin
			offsetVal = pcData;
		end else begin
			offsetVal = Step;
		end
		sum = baseVal + offsetVal;
	end

	// Address to come back to after an interrupt
	assign retAddr = pcA + Step;

	always_comb begin
		case (nextSel)
			pcPkg::NEXT_INTV0: pcNext = `INT0_VECTOR;
			pcPkg::NEXT_INTV1: pcNext = `INT1_VECTOR;
			pcPkg::NEXT_INTR0: pcNext = intRet0;
			pcPkg::NEXT_INTR1: pcNext = intRet1;
			default:           pcNext = sum;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pcA <= `RESET_PC;
		end else if (pcLoad) begin
			pcA <= pcNext;
		end
	end

	// Return registers
	always_ff @(posedge CLK) begin
		if (ldInt0) begin
			intRet0 <= retAddr;
		end
		if (ldInt1) begin
			intRet1 <= retAddr;
		end
	end

endmodule

`default_nettype wire

// File: fetchPort.sv
`default_nettype none

module fetchPort (
	input  wire logic           CLK,
	input  wire logic           rstN,
	input  wire pcPkg::addrT    pcA,
	output pcPkg::addrT         paddr,
	output logic                psel,
	output logic                penable,
	output logic                pwrite,
	input  wire pcPkg::instrT   prdata,
	input  wire logic           pready,
	output pcPkg::instrT        instr,
	output logic                instrValid
);

	pcPkg::fetchStateT state;
	pcPkg::fetchStateT stateNext;
	logic              startFetch;
	logic              done;

	// Transfer completes when psel, penable and pready are all high
	assign done = (state == pcPkg::ACCESS) && pready;

	// Wait out the instrValid cycle so pcA has settled
	assign startFetch = (state == pcPkg::IDLE) && !instrValid;

	always_comb begin
		stateNext = state;
		case (state)
			pcPkg::IDLE: begin
				if (startFetch) begin
					stateNext = pcPkg::SETUP;
				end
			end
			pcPkg::SETUP: begin
				stateNext = pcPkg::ACCESS;
			end
			pcPkg::ACCESS: begin
				if (pready) begin
					stateNext = pcPkg::IDLE;
				end
			end
			default: begin
				stateNext = pcPkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state      <= pcPkg::IDLE;
			instrValid <= 1'b0;
		end else begin
			state      <= stateNext;
			instrValid <= done;
		end
	end

	// Address held from SETUP through any wait states
	always_ff @(posedge CLK) begin
		if (startFetch) begin
			paddr <= pcA;
		end
	end

	always_ff @(posedge CLK) begin
		if (done) begin
			instr <= prdata;
		end
	end

	assign psel    = (state != pcPkg::IDLE);
	assign penable = (state == pcPkg::ACCESS);

	// Read-only master
	assign pwrite = 1'b0;

endmodule

`default_nettype wire

// File: pcSubsystem.sv
`default_nettype none

module pcSubsystem (
	input  wire logic           CLK,
	input  wire logic           rstN,
	output pcPkg::addrT         paddr,
	output logic                psel,
	output logic                penable,
	output logic                pwrite,
	input  wire pcPkg::instrT   prdata,
	input  wire logic           pready,
	input  wire logic           int0Req,
	input  wire logic           int1Req,
	output pcPkg::addrT         pcA,
	output logic                instrValid
);

	pcPkg::instrT      instr;
	logic              pcLoad;
	pcPkg::baseSelT    baseSel;
	pcPkg::offsetSelT  offsetSel;
	pcPkg::nextSelT    nextSel;
	logic              ldInt0;
	logic              ldInt1;
	pcPkg::addrT       pcData;

	instrDecode instrDecode_inst (
		.CLK        (CLK),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.int0Req    (int0Req),
		.int1Req    (int1Req),
		.pcLoad     (pcLoad),
		.baseSel    (baseSel),
		.offsetSel  (offsetSel),
		.nextSel    (nextSel),
		.ldInt0     (ldInt0),
		.ldInt1     (ldInt1),
		.pcData     (pcData)
	);

	// Lookahead address is not needed while only one fetch is in flight
	programCounter programCounter_inst (
		.CLK       (CLK),
		.rstN      (rstN),
		.pcLoad    (pcLoad),
		.baseSel   (baseSel),
		.offsetSel (offsetSel),
		.nextSel   (nextSel),
		.ldInt0    (ldInt0),
		.ldInt1    (ldInt1),
		.pcData    (pcData),
		.pcA       (pcA),
		.pcNext    ()
	);

	fetchPort fetchPort_inst (
		.CLK        (CLK),
		.rstN       (rstN),
		.pcA        (pcA),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.prdata     (prdata),
		.pready     (pready),
		.instr      (instr),
		.instrValid (instrValid)
	);

endmodule

`default_nettype wire

// File: pcSubsystemTb.sv
`default_nettype none

`include "pcUnit_settings.svh"

module pcSubsystemTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MemWords    = 256;
	localparam int NumInstr    = 400;
	localparam int ResetCycles = 10;
	localparam int DriveDelay  = 2;
	// Each instruction needs at most 7 cycles with 3 wait states
	localparam int CycleLimit  = NumInstr * 8;
	localparam logic [15:0] Step = 16'd2;

	logic         CLK;
	logic         rstN;
	pcPkg::addrT  paddr;
	logic         psel;
	logic         penable;
	logic         pwrite;
	pcPkg::instrT prdata;
	logic         pready;
	logic         int0Req;
	logic         int1Req;
	pcPkg::addrT  pcA;
	logic         instrValid;

	pcPkg::instrT mem [MemWords];

	// Reference model state
	logic [15:0] modelPc;
	logic [15:0] expectPc;
	logic [15:0] modelRet0;
	logic [15:0] modelRet1;
	logic        modelIn0;
	logic        modelIn1;
	logic        pcPending;

	logic        prevPsel;
	logic [15:0] prevPaddr;
	logic        prevDone;
	logic        setupSeen;
	int          idleCycles;
	int          waitsLeft;
	int          errors;
	int          checks;
	int          instrCount;
	int          cycleCount;
	int          entries0;
	int          entries1;
	int          returns;

	pcSubsystem pcSubsystem_inst (
		.CLK        (CLK),
		.rstN       (rstN),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.prdata     (prdata),
		.pready     (pready),
		.int0Req    (int0Req),
		.int1Req    (int1Req),
		.pcA        (pcA),
		.instrValid (instrValid)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// Program word, mostly NEXT, with jump targets kept inside the memory
	function automatic pcPkg::instrT randomWord();
		int          pick;
		logic [3:0]  opcode;
		logic [11:0] operand;
		logic [6:0]  relBits;
		pick    = $urandom_range(99);
		operand = 12'($urandom);
		relBits = 7'($urandom);
		if (pick < 55) begin
			opcode = `OP_NEXT;
		end else if (pick < 63) begin
			opcode = 4'($urandom_range(15, 5));
		end else if (pick < 75) begin
			opcode  = `OP_JREL;
			operand = {{5{relBits[6]}}, relBits[6:1], 1'b0};
		end else if (pick < 85) begin
			opcode  = `OP_JABS;
			operand = {3'b000, 8'($urandom), 1'b0};
		end else if (pick < 92) begin
			opcode = `OP_RETI0;
		end else begin
			opcode = `OP_RETI1;
		end
		return {opcode, operand};
	endfunction

	task automatic stepModel(input pcPkg::instrT word);
		logic [3:0]  opcode;
		logic [11:0] operand;
		opcode  = word[15:12];
		operand = word[11:0];
		case (opcode)
			`OP_JREL: expectPc = modelPc + {{4{operand[11]}}, operand};
			`OP_JABS: expectPc = {4'h0, operand};
			`OP_RETI0: begin
				expectPc = modelRet0;
				modelIn0 = 1'b0;
				returns++;
			end
			`OP_RETI1: begin
				expectPc = modelRet1;
				modelIn1 = 1'b0;
				returns++;
			end
			default: begin
				if (int0Req && !modelIn0) begin
					modelRet0 = modelPc + Step;
					modelIn0  = 1'b1;
					expectPc  = `INT0_VECTOR;
					entries0++;
				end else if (int1Req && !modelIn1) begin
					modelRet1 = modelPc + Step;
					modelIn1  = 1'b1;
					expectPc  = `INT1_VECTOR;
					entries1++;
				end else begin
					expectPc = modelPc + Step;
				end
			end
		endcase
	endtask

	task automatic driveApb();
		if (psel && !penable) begin
			waitsLeft = $urandom_range(3);
			pready    = 1'b0;
			prdata    = 16'($urandom);
		end else if (psel && penable && waitsLeft == 0) begin
			pready = 1'b1;
			prdata = mem[paddr[8:1]];
		end else begin
			if (psel && penable) begin
				waitsLeft--;
			end
			pready = 1'b0;
			prdata = 16'($urandom);
		end
	endtask

	// First two instructions enter level 0 and then level 1
	task automatic toggleRequests();
		if (instrCount < 2) begin
			int0Req = 1'b1;
			int1Req = 1'b1;
		end else begin
			if ($urandom_range(5) == 0) begin
				int0Req = !int0Req;
			end
			if ($urandom_range(5) == 0) begin
				int1Req = !int1Req;
			end
		end
	endtask

	task automatic checkBus();
		if (!setupSeen && !psel) begin
			idleCycles++;
		end
		if (psel && !prevPsel) begin
			if (!setupSeen) begin
				checkValue("cycles before first SETUP", 16'd1, 16'(idleCycles));
				setupSeen = 1'b1;
			end
			checkValue("paddr", modelPc, paddr);
		end
		checkValue("penable", 16'(psel && prevPsel), 16'(penable));
		// Address held through ACCESS and wait states
		if (psel && prevPsel) begin
			checkValue("paddr", prevPaddr, paddr);
		end
		checkValue("pwrite", 16'd0, 16'(pwrite));
		// Valid pulse only in the cycle after the completing edge
		checkValue("instrValid", 16'(prevDone), 16'(instrValid));
	endtask

	task automatic checkFlow();
		if (pcPending) begin
			modelPc   = expectPc;
			pcPending = 1'b0;
		end
		checkValue("pcA", modelPc, pcA);
		if (instrValid) begin
			checkValue("instr", mem[modelPc[8:1]], pcSubsystem_inst.instr);
			stepModel(mem[modelPc[8:1]]);
			pcPending = 1'b1;
			instrCount++;
		end
	endtask

	// Stimulus a short delay after each rising edge
	initial begin
		pready    = 1'b0;
		prdata    = '0;
		int0Req   = 1'b1;
		int1Req   = 1'b1;
		waitsLeft = 0;
		forever begin
			@(posedge CLK);
			#DriveDelay;
			driveApb();
			toggleRequests();
		end
	end

	// Outputs sampled on the falling edge
	initial begin
		modelPc    = `RESET_PC;
		expectPc   = `RESET_PC;
		modelRet0  = '0;
		modelRet1  = '0;
		modelIn0   = 1'b0;
		modelIn1   = 1'b0;
		pcPending  = 1'b0;
		prevPsel   = 1'b0;
		prevPaddr  = '0;
		prevDone   = 1'b0;
		setupSeen  = 1'b0;
		idleCycles = 0;
		forever begin
			@(negedge CLK);
			if (!rstN) begin
				checkValue("psel", 16'd0, 16'(psel));
				checkValue("penable", 16'd0, 16'(penable));
				checkValue("instrValid", 16'd0, 16'(instrValid));
			end else begin
				checkBus();
				checkFlow();
			end
			prevPsel  = psel;
			prevPaddr = paddr;
			prevDone  = psel && penable && pready;
		end
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < CycleLimit) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Timeout: only %0d of %0d instructions finished in %0d cycles",
			instrCount, NumInstr, cycleCount);
		$display("Instructions %0d, checks %0d, errors %0d", instrCount, checks, errors);
		$display("Errors found");
		$finish;
	end

	initial begin
		errors     = 0;
		checks     = 0;
		instrCount = 0;
		entries0   = 0;
		entries1   = 0;
		returns    = 0;
		rstN       = 1'b0;
		void'($urandom(32'h35ad));
		for (int i = 0; i < MemWords; i++) begin
			mem[i] = randomWord();
		end
		// Words at 0000 and 0004 run as NEXT so both return registers get loaded
		mem[0][15:12] = `OP_NEXT;
		mem[2][15:12] = `OP_NEXT;
		repeat (ResetCycles) @(posedge CLK);
		#DriveDelay;
		rstN = 1'b1;
		while (instrCount < NumInstr) begin
			@(posedge CLK);
		end
		repeat (2) @(posedge CLK);
		$display("Instr %0d, int0 %0d, int1 %0d, returns %0d, checks %0d, errors %0d",
			instrCount, entries0, entries1, returns, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
pcPkg.sv
instrDecode.sv
programCounter.sv
fetchPort.sv
pcSubsystem.sv
pcSubsystemTb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f list.f \
	--top-module pcSubsystemTb -o pcSubsystemSim > build.log 2>&1 \
	&& ./obj_dir/pcSubsystemSim > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -qx "No errors" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
